/* compile.f */
source/core_types_pkg.sv
source/issue_config_pkg.sv
source/dispatch_decode.sv
source/issue_queue.sv
source/alu_execute.sv
source/result_writeback.sv
source/ooo_exec_top.sv
tb/ooo_exec_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module ooo_exec_tb -f compile.f
./obj_dir/Vooo_exec_tb | tee sim.log

if grep -q "All tests passed!" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* source/alu_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_execute
    import core_types_pkg::*;
(
    input  wire logic                     clk_in,
    input  wire logic                     reset_in,
    input  wire logic                     issue_valid,
    input  wire alu_op_t                  issue_op,
    input  wire logic [tag_width-1:0]     issue_dest_tag,
    input  wire logic [operand_width-1:0] issue_rs_value,
    input  wire logic [operand_width-1:0] issue_rt_value,
    output logic                          result_valid,
    output logic [tag_width-1:0]          result_tag,
    output logic [operand_width-1:0]      result_value
);

    logic [operand_width-1:0] alu_value;

    always_comb
    begin
        case (issue_op)
            op_add: alu_value = issue_rs_value + issue_rt_value;
            op_sub: alu_value = issue_rs_value - issue_rt_value;
            op_and: alu_value = issue_rs_value & issue_rt_value;
            op_xor: alu_value = issue_rs_value ^ issue_rt_value;
            default: alu_value = '0;
        endcase
    end

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
            result_valid <= 1'b0;
        else
            result_valid <= issue_valid;
    end

    // result payload follows the valid bit
    always_ff @(posedge clk_in)
    begin
        if (issue_valid)
        begin
            result_tag <= issue_dest_tag;
            result_value <= alu_value;
        end
    end

endmodule

`default_nettype wire

/* source/core_types_pkg.sv */
`default_nettype none

package core_types_pkg;

    localparam int operand_width = 32;
    localparam int tag_width = 4;
    localparam int num_tags = 16;

    typedef enum logic [1:0] {
        op_add = 2'd0,
        op_sub = 2'd1,
        op_and = 2'd2,
        op_xor = 2'd3
    } alu_op_t;

    // opcode field encodings, everything else is illegal
    localparam int opcode_width = 4;
    localparam logic [opcode_width-1:0] opcode_add = 4'd1;
    localparam logic [opcode_width-1:0] opcode_sub = 4'd2;
    localparam logic [opcode_width-1:0] opcode_and = 4'd3;
    localparam logic [opcode_width-1:0] opcode_xor = 4'd4;

    // instruction word fields
    localparam int word_width = 16;
    localparam int opcode_msb = 15;
    localparam int opcode_lsb = 12;
    localparam int dest_msb = 11;
    localparam int dest_lsb = 8;
    localparam int rs_msb = 7;
    localparam int rs_lsb = 4;
    localparam int rt_msb = 3;
    localparam int rt_lsb = 0;

endpackage

`default_nettype wire

/* source/dispatch_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module dispatch_decode
    import core_types_pkg::*;
(
    input  wire logic                     clk_in,
    input  wire logic                     reset_in,
    input  wire logic                     dispatch_valid,
    input  wire logic [15:0]              dispatch_word,
    input  wire logic                     issue_full,
    input  wire logic                     bcast_valid,
    input  wire logic [tag_width-1:0]     bcast_tag,
    input  wire logic [operand_width-1:0] bcast_value,
    input  wire logic                     file_rs_valid,
    input  wire logic [operand_width-1:0] file_rs_value,
    input  wire logic                     file_rt_valid,
    input  wire logic [operand_width-1:0] file_rt_value,
    output logic [tag_width-1:0]          file_rs_tag,
    output logic [tag_width-1:0]          file_rt_tag,
    output logic                          alloc_valid,
    output alu_op_t                       alloc_op,
    output logic [tag_width-1:0]          alloc_dest_tag,
    output logic [tag_width-1:0]          alloc_rs_tag,
    output logic                          alloc_rs_ready,
    output logic [operand_width-1:0]      alloc_rs_value,
    output logic [tag_width-1:0]          alloc_rt_tag,
    output logic                          alloc_rt_ready,
    output logic [operand_width-1:0]      alloc_rt_value,
    output logic                          illegal_op
);

    logic [opcode_width-1:0] opcode;
    logic                    op_legal;
    logic                    rs_hit;
    logic                    rt_hit;

    assign opcode = dispatch_word[opcode_msb:opcode_lsb];

    always_comb
    begin
        op_legal = 1'b1;
        alloc_op = op_add;
        case (opcode)
            opcode_add: alloc_op = op_add;
            opcode_sub: alloc_op = op_sub;
            opcode_and: alloc_op = op_and;
            opcode_xor: alloc_op = op_xor;
            default:    op_legal = 1'b0;
        endcase
    end

    // an illegal word never reaches the queue
    assign alloc_valid = dispatch_valid && op_legal;
    assign illegal_op = dispatch_valid && !op_legal;

    assign alloc_dest_tag = dispatch_word[dest_msb:dest_lsb];
    assign alloc_rs_tag = dispatch_word[rs_msb:rs_lsb];
    assign alloc_rt_tag = dispatch_word[rt_msb:rt_lsb];
    assign file_rs_tag = alloc_rs_tag;
    assign file_rt_tag = alloc_rt_tag;

    // same-cycle broadcast wins over the file copy
    assign rs_hit = bcast_valid && (bcast_tag == alloc_rs_tag);
    assign rt_hit = bcast_valid && (bcast_tag == alloc_rt_tag);
    assign alloc_rs_ready = rs_hit || file_rs_valid;
    assign alloc_rt_ready = rt_hit || file_rt_valid;
    assign alloc_rs_value = rs_hit ? bcast_value : file_rs_value;
    assign alloc_rt_value = rt_hit ? bcast_value : file_rt_value;

    dispatch_while_full: assert property (
        @(posedge clk_in) disable iff (reset_in) !(dispatch_valid && issue_full))
        else $error("dispatch driven while issue queue is full");

endmodule

`default_nettype wire

/* source/issue_config_pkg.sv */
`default_nettype none

package issue_config_pkg;

    // number of issue queue entries
    localparam int iq_depth = 6;

    localparam int iq_index_width = $clog2(iq_depth);

endpackage

`default_nettype wire

/* source/issue_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_queue
    import core_types_pkg::*, issue_config_pkg::*;
(
    input  wire logic                     clk_in,
    input  wire logic                     reset_in,
    input  wire logic                     alloc_valid,
    input  wire alu_op_t                  alloc_op,
    input  wire logic [tag_width-1:0]     alloc_dest_tag,
    input  wire logic [tag_width-1:0]     alloc_rs_tag,
    input  wire logic                     alloc_rs_ready,
    input  wire logic [operand_width-1:0] alloc_rs_value,
    input  wire logic [tag_width-1:0]     alloc_rt_tag,
    input  wire logic                     alloc_rt_ready,
    input  wire logic [operand_width-1:0] alloc_rt_value,
    input  wire logic                     bcast_valid,
    input  wire logic [tag_width-1:0]     bcast_tag,
    input  wire logic [operand_width-1:0] bcast_value,
    output logic                          issue_full,
    output logic                          issue_valid,
    output alu_op_t                       issue_op,
    output logic [tag_width-1:0]          issue_dest_tag,
    output logic [operand_width-1:0]      issue_rs_value,
    output logic [operand_width-1:0]      issue_rt_value
);

    logic [iq_depth-1:0]       busy;
    logic [iq_depth-1:0]       rs_ready;
    logic [iq_depth-1:0]       rt_ready;
    alu_op_t                   entry_op [iq_depth];
    logic [tag_width-1:0]      entry_dest [iq_depth];
    logic [tag_width-1:0]      entry_rs_tag [iq_depth];
    logic [tag_width-1:0]      entry_rt_tag [iq_depth];
    logic [operand_width-1:0]  entry_rs_value [iq_depth];
    logic [operand_width-1:0]  entry_rt_value [iq_depth];

    logic [iq_depth-1:0]       rs_wake;
    logic [iq_depth-1:0]       rt_wake;
    logic [iq_depth-1:0]       ready_vec;
    logic                      free_found;
    logic                      alloc_fire;
    logic [iq_index_width-1:0] alloc_index;
    logic [iq_index_width-1:0] sel_index;

    assign issue_full = &busy;
    assign alloc_fire = alloc_valid && free_found;

    // ready bits are only ever set on busy entries
    assign ready_vec = rs_ready & rt_ready;

    always_comb
    begin
        for (int i = 0; i < iq_depth; i++)
        begin
            rs_wake[i] = busy[i] && !rs_ready[i] && bcast_valid && (bcast_tag == entry_rs_tag[i]);
            rt_wake[i] = busy[i] && !rt_ready[i] && bcast_valid && (bcast_tag == entry_rt_tag[i]);
        end
    end

    // lowest free entry
    always_comb
    begin
        free_found = 1'b0;
        alloc_index = '0;
        for (int i = 0; i < iq_depth; i++)
        begin
            if (!busy[i] && !free_found)
            begin
                free_found = 1'b1;
                alloc_index = iq_index_width'(i);
            end
        end
    end

    // lowest ready entry
    always_comb
    begin
        issue_valid = 1'b0;
        sel_index = '0;
        for (int i = 0; i < iq_depth; i++)
        begin
            if (ready_vec[i] && !issue_valid)
            begin
                issue_valid = 1'b1;
                sel_index = iq_index_width'(i);
            end
        end
    end

    assign issue_op = entry_op[sel_index];
    assign issue_dest_tag = entry_dest[sel_index];
    assign issue_rs_value = entry_rs_value[sel_index];
    assign issue_rt_value = entry_rt_value[sel_index];

    always_ff @(posedge clk_in)
    begin
        for (int i = 0; i < iq_depth; i++)
        begin
            if (reset_in)
            begin
                busy[i] <= 1'b0;
                rs_ready[i] <= 1'b0;
                rt_ready[i] <= 1'b0;
            end
            else if (alloc_fire && alloc_index == iq_index_width'(i))
            begin
                busy[i] <= 1'b1;
                rs_ready[i] <= alloc_rs_ready;
                rt_ready[i] <= alloc_rt_ready;
            end
            else if (issue_valid && sel_index == iq_index_width'(i))
            begin
                busy[i] <= 1'b0;
                rs_ready[i] <= 1'b0;
                rt_ready[i] <= 1'b0;
            end
            else
            begin
                if (rs_wake[i])
                    rs_ready[i] <= 1'b1;
                if (rt_wake[i])
                    rt_ready[i] <= 1'b1;
            end
        end
    end

    // entry payload, written on allocation and wake-up capture
    always_ff @(posedge clk_in)
    begin
        for (int i = 0; i < iq_depth; i++)
        begin
            if (alloc_fire && alloc_index == iq_index_width'(i))
            begin
                entry_op[i] <= alloc_op;
                entry_dest[i] <= alloc_dest_tag;
                entry_rs_tag[i] <= alloc_rs_tag;
                entry_rt_tag[i] <= alloc_rt_tag;
                entry_rs_value[i] <= alloc_rs_value;
                entry_rt_value[i] <= alloc_rt_value;
            end
            else
            begin
                if (rs_wake[i])
                    entry_rs_value[i] <= bcast_value;
                if (rt_wake[i])
                    entry_rt_value[i] <= bcast_value;
            end
        end
    end

    alloc_while_full: assert property (
        @(posedge clk_in) disable iff (reset_in) alloc_valid |-> !issue_full)
        else $error("allocation into a full issue queue");

    issue_not_busy: assert property (
        @(posedge clk_in) disable iff (reset_in) issue_valid |-> busy[sel_index])
        else $error("issue from an entry that holds no instruction");

endmodule

`default_nettype wire

/* source/ooo_exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ooo_exec_top
    import core_types_pkg::*;
(
    input  wire logic                     clk_in,
    input  wire logic                     reset_in,
    input  wire logic                     preload_valid,
    input  wire logic [tag_width-1:0]     preload_tag,
    input  wire logic [operand_width-1:0] preload_value,
    input  wire logic                     dispatch_valid,
    input  wire logic [15:0]              dispatch_word,
    output logic                          issue_full,
    output logic                          illegal_op,
    output logic                          complete_valid,
    output logic [tag_width-1:0]          complete_tag,
    output logic [operand_width-1:0]      complete_value
);

    logic                     bcast_valid;
    logic [tag_width-1:0]     bcast_tag;
    logic [operand_width-1:0] bcast_value;
    logic [tag_width-1:0]     file_rs_tag;
    logic [tag_width-1:0]     file_rt_tag;
    logic                     file_rs_valid;
    logic                     file_rt_valid;
    logic [operand_width-1:0] file_rs_value;
    logic [operand_width-1:0] file_rt_value;
    logic                     alloc_valid;
    alu_op_t                  alloc_op;
    logic [tag_width-1:0]     alloc_dest_tag;
    logic [tag_width-1:0]     alloc_rs_tag;
    logic [tag_width-1:0]     alloc_rt_tag;
    logic                     alloc_rs_ready;
    logic                     alloc_rt_ready;
    logic [operand_width-1:0] alloc_rs_value;
    logic [operand_width-1:0] alloc_rt_value;
    logic                     issue_valid;
    alu_op_t                  issue_op;
    logic [tag_width-1:0]     issue_dest_tag;
    logic [operand_width-1:0] issue_rs_value;
    logic [operand_width-1:0] issue_rt_value;
    logic                     result_valid;
    logic [tag_width-1:0]     result_tag;
    logic [operand_width-1:0] result_value;

    dispatch_decode u_decode (
        .clk_in, .reset_in, .dispatch_valid, .dispatch_word, .issue_full,
        .bcast_valid, .bcast_tag, .bcast_value,
        .file_rs_valid, .file_rs_value, .file_rt_valid, .file_rt_value,
        .file_rs_tag, .file_rt_tag,
        .alloc_valid, .alloc_op, .alloc_dest_tag,
        .alloc_rs_tag, .alloc_rs_ready, .alloc_rs_value,
        .alloc_rt_tag, .alloc_rt_ready, .alloc_rt_value,
        .illegal_op
    );

    issue_queue u_queue (
        .clk_in, .reset_in,
        .alloc_valid, .alloc_op, .alloc_dest_tag,
        .alloc_rs_tag, .alloc_rs_ready, .alloc_rs_value,
        .alloc_rt_tag, .alloc_rt_ready, .alloc_rt_value,
        .bcast_valid, .bcast_tag, .bcast_value,
        .issue_full, .issue_valid, .issue_op, .issue_dest_tag,
        .issue_rs_value, .issue_rt_value
    );

    alu_execute u_alu (
        .clk_in, .reset_in, .issue_valid, .issue_op, .issue_dest_tag,
        .issue_rs_value, .issue_rt_value, .result_valid, .result_tag, .result_value
    );

    result_writeback u_writeback (
        .clk_in, .reset_in, .preload_valid, .preload_tag, .preload_value,
        .dispatch_fire(alloc_valid), .dispatch_dest_tag(alloc_dest_tag),
        .result_valid, .result_tag, .result_value,
        .file_rs_tag, .file_rt_tag,
        .file_rs_valid, .file_rs_value, .file_rt_valid, .file_rt_value,
        .bcast_valid, .bcast_tag, .bcast_value
    );

    // completion is the broadcast itself
    assign complete_valid = bcast_valid;
    assign complete_tag = bcast_tag;
    assign complete_value = bcast_value;

endmodule

`default_nettype wire

/* source/result_writeback.sv */
`timescale 1ns/1ps
`default_nettype none

module result_writeback
    import core_types_pkg::*;
(
    input  wire logic                     clk_in,
    input  wire logic                     reset_in,
    input  wire logic                     preload_valid,
    input  wire logic [tag_width-1:0]     preload_tag,
    input  wire logic [operand_width-1:0] preload_value,
    input  wire logic                     dispatch_fire,
    input  wire logic [tag_width-1:0]     dispatch_dest_tag,
    input  wire logic                     result_valid,
    input  wire logic [tag_width-1:0]     result_tag,
    input  wire logic [operand_width-1:0] result_value,
    input  wire logic [tag_width-1:0]     file_rs_tag,
    input  wire logic [tag_width-1:0]     file_rt_tag,
    output logic                          file_rs_valid,
    output logic [operand_width-1:0]      file_rs_value,
    output logic                          file_rt_valid,
    output logic [operand_width-1:0]      file_rt_value,
    output logic                          bcast_valid,
    output logic [tag_width-1:0]          bcast_tag,
    output logic [operand_width-1:0]      bcast_value
);

    logic [operand_width-1:0] tag_value [num_tags];
    logic [num_tags-1:0]      tag_valid;

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            tag_valid <= '1;
            for (int i = 0; i < num_tags; i++)
                tag_value[i] <= '0;
        end
        else
        begin
            // destination goes pending at dispatch
            if (dispatch_fire)
                tag_valid[dispatch_dest_tag] <= 1'b0;
            if (preload_valid)
            begin
                tag_valid[preload_tag] <= 1'b1;
                tag_value[preload_tag] <= preload_value;
            end
            if (result_valid)
            begin
                tag_valid[result_tag] <= 1'b1;
                tag_value[result_tag] <= result_value;
            end
        end
    end

    assign file_rs_valid = tag_valid[file_rs_tag];
    assign file_rs_value = tag_value[file_rs_tag];
    assign file_rt_valid = tag_valid[file_rt_tag];
    assign file_rt_value = tag_value[file_rt_tag];

    // alu register drives the broadcast directly
    assign bcast_valid = result_valid;
    assign bcast_tag = result_tag;
    assign bcast_value = result_value;

    result_to_valid_tag: assert property (
        @(posedge clk_in) disable iff (reset_in) result_valid |-> !tag_valid[result_tag])
        else $error("result for a tag that was not pending");

endmodule

`default_nettype wire

/* tb/ooo_exec_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ooo_exec_tb
    import core_types_pkg::*, issue_config_pkg::*;
();

    // 8+6+3+14+13+300 dispatches over the test sections
    localparam int total_dispatches = 344;
    localparam int timeout_cycles = (total_dispatches + 50) * 20;
    localparam int random_dispatches = 300;

    logic                     clk_in;
    logic                     reset_in;
    logic                     preload_valid;
    logic [tag_width-1:0]     preload_tag;
    logic [operand_width-1:0] preload_value;
    logic                     dispatch_valid;
    logic [word_width-1:0]    dispatch_word;
    logic                     issue_full;
    logic                     illegal_op;
    logic                     complete_valid;
    logic [tag_width-1:0]     complete_tag;
    logic [operand_width-1:0] complete_value;

    // expected state kept by the stimulus process
    logic [operand_width-1:0] model_value [num_tags];
    logic [operand_width-1:0] exp_result [num_tags];
    int                       dispatched_cnt [num_tags];
    logic                     exp_illegal;
    int                       fault_count;
    logic [31:0]              rng_state;

    // owned by the compare process
    int                       completed_cnt [num_tags];
    int                       mismatch_count;
    int                       unexpected_count;
    int                       completions;
    int                       full_cycles;
    int                       queue_count;
    logic                     alloc_seen;

    ooo_exec_top dut (
        .clk_in, .reset_in, .preload_valid, .preload_tag, .preload_value,
        .dispatch_valid, .dispatch_word, .issue_full, .illegal_op,
        .complete_valid, .complete_tag, .complete_value
    );

    initial
    begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic is_legal(input logic [3:0] opcode);
        return (opcode >= opcode_add) && (opcode <= opcode_xor);
    endfunction

    function automatic logic [operand_width-1:0] ref_alu(input logic [3:0] opcode,
        input logic [operand_width-1:0] a, input logic [operand_width-1:0] b);
        case (opcode)
            opcode_add: return a + b;
            opcode_sub: return a - b;
            opcode_and: return a & b;
            opcode_xor: return a ^ b;
            default:    return a;
        endcase
    endfunction

    function automatic logic is_pending(input logic [tag_width-1:0] tag);
        return dispatched_cnt[tag] != completed_cnt[tag];
    endfunction

    task automatic check_completion(input logic [tag_width-1:0] tag,
        input logic [operand_width-1:0] value);
        if (!is_pending(tag))
        begin
            $display("unexpected completion for tag %h with no instruction in flight", tag);
            unexpected_count++;
        end
        else
        begin
            if (value !== exp_result[tag])
            begin
                $display("mismatch complete_value for tag %h: got %h, expected %h",
                    tag, value, exp_result[tag]);
                mismatch_count++;
            end
            completed_cnt[tag]++;
        end
        completions++;
    endtask

    task automatic check_illegal(input logic actual, input logic expected);
        if (actual !== expected)
        begin
            $display("mismatch illegal_op: got %h, expected %h", actual, expected);
            mismatch_count++;
        end
    endtask

    task automatic check_full(input logic actual, input logic expected);
        if (actual !== expected)
        begin
            $display("mismatch issue_full: got %h, expected %h", actual, expected);
            mismatch_count++;
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk_in)
    begin
        if (!reset_in)
        begin
            check_illegal(illegal_op, exp_illegal);
            // dispatch seen last cycle was allocated at the edge just passed
            if (alloc_seen)
                queue_count++;
            // a completion now means its entry was freed at that same edge
            if (complete_valid)
            begin
                queue_count--;
                check_completion(complete_tag, complete_value);
            end
            check_full(issue_full, queue_count == iq_depth);
            if (issue_full)
                full_cycles++;
            alloc_seen = dispatch_valid && is_legal(dispatch_word[opcode_msb:opcode_lsb]);
        end
    end

    task automatic next_slot();
        @(posedge clk_in);
        #1;
    endtask

    task automatic load_tag(input logic [tag_width-1:0] tag,
        input logic [operand_width-1:0] value);
        preload_valid = 1'b1;
        preload_tag = tag;
        preload_value = value;
        model_value[tag] = value;
        next_slot();
        preload_valid = 1'b0;
    endtask

    task automatic send_instr(input logic [3:0] opcode, input logic [tag_width-1:0] dest,
        input logic [tag_width-1:0] rs, input logic [tag_width-1:0] rt);
        while (issue_full)
            next_slot();
        dispatch_valid = 1'b1;
        dispatch_word = {opcode, dest, rs, rt};
        exp_illegal = !is_legal(opcode);
        // expected result computed in program order
        if (is_legal(opcode))
        begin
            exp_result[dest] = ref_alu(opcode, model_value[rs], model_value[rt]);
            model_value[dest] = exp_result[dest];
            dispatched_cnt[dest]++;
        end
        next_slot();
        dispatch_valid = 1'b0;
        exp_illegal = 1'b0;
    endtask

    task automatic drain_pending();
        logic busy;
        busy = 1'b1;
        while (busy)
        begin
            busy = 1'b0;
            for (int t = 0; t < num_tags; t++)
                if (is_pending(tag_width'(t)))
                    busy = 1'b1;
            if (busy)
                next_slot();
        end
    endtask

    task automatic pick_free_tag(input logic [tag_width-1:0] start, output logic found,
        output logic [tag_width-1:0] tag);
        logic [tag_width-1:0] cand;
        found = 1'b0;
        tag = start;
        for (int k = 0; k < num_tags; k++)
        begin
            cand = start + tag_width'(k);
            if (!found && !is_pending(cand))
            begin
                found = 1'b1;
                tag = cand;
            end
        end
    endtask

    initial
    begin
        int                   issued;
        int                   full_before;
        logic                 found;
        logic [tag_width-1:0] dest;
        logic [3:0]           opcode;

        reset_in = 1'b1;
        preload_valid = 1'b0;
        preload_tag = '0;
        preload_value = '0;
        dispatch_valid = 1'b0;
        dispatch_word = '0;
        exp_illegal = 1'b0;
        fault_count = 0;
        rng_state = 32'hc94a1731;
        for (int t = 0; t < num_tags; t++)
        begin
            model_value[t] = '0;
            exp_result[t] = '0;
            dispatched_cnt[t] = 0;
        end
        repeat (5) @(posedge clk_in);
        #1;
        reset_in = 1'b0;
        next_slot();

        // independent instructions of every op
        for (int t = 0; t < num_tags; t++)
        begin
            rng_state = xorshift(rng_state);
            load_tag(tag_width'(t), rng_state);
        end
        for (int i = 0; i < 8; i++)
            send_instr(4'd1 + 4'(i % 4), tag_width'(8 + i), tag_width'(i),
                tag_width'(7 - i));
        drain_pending();

        // dependence chain through wake-up
        for (int i = 0; i < 6; i++)
            send_instr(4'd1 + 4'(i % 4), tag_width'(i + 1), tag_width'(i),
                tag_width'(15 - i));
        drain_pending();

        // consumer dispatched while its producer broadcasts
        send_instr(opcode_add, 4'd2, 4'd3, 4'd4);
        send_instr(opcode_xor, 4'd5, 4'd6, 4'd7);
        if (!(complete_valid && complete_tag == 4'd2))
        begin
            $display("producer broadcast not present in the consumer dispatch cycle");
            fault_count++;
        end
        send_instr(opcode_sub, 4'd9, 4'd2, 4'd8);
        drain_pending();

        // long chain keeps six waiters parked until the queue fills
        full_before = full_cycles;
        for (int i = 0; i < 8; i++)
            send_instr(4'd1 + 4'(i % 4), tag_width'(i + 1), tag_width'(i), 4'd15);
        for (int i = 0; i < 6; i++)
            send_instr(4'd1 + 4'(i % 4), tag_width'(9 + i), 4'd8, 4'd0);
        drain_pending();
        if (full_cycles == full_before)
        begin
            $display("issue_full never went high while the queue was filled");
            fault_count++;
        end

        // illegal opcodes leave the dest tag untouched
        for (int op = 0; op < 16; op++)
        begin
            if (!is_legal(4'(op)))
            begin
                send_instr(4'(op), 4'd3, 4'd1, 4'd2);
                next_slot();
            end
        end
        send_instr(opcode_add, 4'd4, 4'd3, 4'd3);
        drain_pending();

        issued = 0;
        while (issued < random_dispatches)
        begin
            rng_state = xorshift(rng_state);
            if (rng_state[31:29] == 3'd0)
                next_slot();
            else
            begin
                pick_free_tag(rng_state[11:8], found, dest);
                if (!found)
                    next_slot();
                else
                begin
                    if (rng_state[5:4] == 2'd0)
                        opcode = rng_state[3:0];
                    else
                        opcode = 4'd1 + {2'b00, rng_state[7:6]};
                    send_instr(opcode, dest, rng_state[15:12], rng_state[19:16]);
                    issued++;
                end
            end
        end
        drain_pending();
        repeat (4) next_slot();

        $display("mismatches %0d, unexpected completions %0d, test faults %0d, completions %0d",
            mismatch_count, unexpected_count, fault_count, completions);
        if (mismatch_count + unexpected_count + fault_count == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    initial
    begin
        mismatch_count = 0;
        unexpected_count = 0;
        completions = 0;
        full_cycles = 0;
        queue_count = 0;
        alloc_seen = 1'b0;
        for (int t = 0; t < num_tags; t++)
            completed_cnt[t] = 0;
    end

    initial
    begin
        repeat (timeout_cycles) @(posedge clk_in);
        $display("timeout after %0d cycles with instructions still outstanding",
            timeout_cycles);
        $display("mismatches %0d, unexpected completions %0d, test faults %0d, completions %0d",
            mismatch_count, unexpected_count, fault_count, completions);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire
